// ==== hw/wb_defines.svh ====
// writeback defines: datapath widths, register count and x86 flag bit positions
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// datapath and address width
`define WB_DATA_W 32

// general register file
`define WB_GPR_N 8
`define WB_REG_W 3

// flag bit positions, x86 layout
`define WB_FLAG_OF 11
`define WB_FLAG_DF 10
`define WB_FLAG_SF 7
`define WB_FLAG_ZF 6
`define WB_FLAG_AF 4
`define WB_FLAG_PF 2
`define WB_FLAG_CF 0

`endif

// ==== hw/wb_pkg.sv ====
// writeback package: micro-op kinds, operand sizes and the micro-op record
`include "wb_defines.svh"

package wb_pkg;

  // micro-op kind as seen at retire
  typedef enum logic [2:0] {
    WB_OP_ALU   = 3'd0,
    WB_OP_STORE = 3'd1,
    WB_OP_CMPS  = 3'd2,
    WB_OP_REPNE = 3'd3,
    WB_OP_NOP   = 3'd4
  } wb_op_e;

  // operand size, also the string pointer step
  typedef enum logic [1:0] {
    WB_SIZE_BYTE  = 2'd0,
    WB_SIZE_WORD  = 2'd1,
    WB_SIZE_DWORD = 2'd2
  } wb_size_e;

  // flags_mask order is OF DF SF ZF AF PF CF, OF in the top bit
  typedef struct packed {
    wb_op_e                 op;
    wb_size_e               size;
    logic [`WB_REG_W-1:0]   dst;
    logic [`WB_DATA_W-1:0]  result;
    logic [`WB_DATA_W-1:0]  pointer;
    logic [`WB_DATA_W-1:0]  count;
    logic [`WB_DATA_W-1:0]  address;
    logic [`WB_DATA_W-1:0]  new_flags;
    logic [6:0]             flags_mask;
  } wb_uop_t;

endpackage

// ==== hw/wb_uop_if.sv ====
// micro-op commit channel from the input latch to the retire blocks
`timescale 1ns/1ns

interface wb_uop_if;

  // single-cycle strobe, uop stays valid until the next accept
  logic            commit;
  wb_pkg::wb_uop_t uop;

  // latch side
  modport src (
    output commit,
    output uop
  );

  // flags, string, register file and store port side
  modport dst (
    input commit,
    input uop
  );

endinterface

// ==== hw/wb_input_latch.sv ====
// input latch: four-phase receiver that holds one micro-op and stalls stores on a busy port
`timescale 1ns/1ns

module wb_input_latch (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_req,
  input  wb_pkg::wb_uop_t in_uop,
  output logic            in_ack,
  input  logic            store_busy,
  wb_uop_if.src           uop_out
);

  typedef enum logic {
    WAIT_REQ,
    WAIT_DROP
  } state_e;

  state_e          state;
  logic            commit_q;
  logic            accept;
  wb_pkg::wb_uop_t held_uop;

  // a store has to wait for the previous one to leave the cache bus,
  // everything else goes straight through
  assign accept = (state == WAIT_REQ) && in_req &&
                  !((in_uop.op == wb_pkg::WB_OP_STORE) && store_busy);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= WAIT_REQ;
      in_ack   <= 1'b0;
      commit_q <= 1'b0;
    end else begin
      commit_q <= 1'b0;
      case (state)
        WAIT_REQ: begin
          if (accept) begin
            commit_q <= 1'b1;
            in_ack   <= 1'b1;
            state    <= WAIT_DROP;
          end
        end
        WAIT_DROP: begin
          // sender released req, close the handshake
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= WAIT_REQ;
          end
        end
        default: state <= WAIT_REQ;
      endcase
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      held_uop <= in_uop;
    end
  end

  assign uop_out.commit = commit_q;
  assign uop_out.uop    = held_uop;

endmodule

// ==== hw/wb_flags_unit.sv ====
// flags unit: architectural flags register with per-micro-op masked merge
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_flags_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  wb_uop_if.dst                 uop_in,
  output logic [`WB_DATA_W-1:0] flags
);

  logic [`WB_DATA_W-1:0] mask_word;
  logic                  load_flags;

  // spread the 7-bit mask onto the x86 bit positions
  always_comb begin
    mask_word                = '0;
    mask_word[`WB_FLAG_OF]   = uop_in.uop.flags_mask[6];
    mask_word[`WB_FLAG_DF]   = uop_in.uop.flags_mask[5];
    mask_word[`WB_FLAG_SF]   = uop_in.uop.flags_mask[4];
    mask_word[`WB_FLAG_ZF]   = uop_in.uop.flags_mask[3];
    mask_word[`WB_FLAG_AF]   = uop_in.uop.flags_mask[2];
    mask_word[`WB_FLAG_PF]   = uop_in.uop.flags_mask[1];
    mask_word[`WB_FLAG_CF]   = uop_in.uop.flags_mask[0];
  end

  // only ALU and CMPS micro-ops touch flags
  assign load_flags = uop_in.commit &&
                      ((uop_in.uop.op == wb_pkg::WB_OP_ALU) ||
                       (uop_in.uop.op == wb_pkg::WB_OP_CMPS));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (load_flags) begin
      // unselected bits keep their old value
      flags <= (flags & ~mask_word) | (uop_in.uop.new_flags & mask_word);
    end
  end

endmodule

// ==== hw/wb_string_unit.sv ====
// string unit: CMPS pointer stepping and REPNE count update with loop termination
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_string_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  wb_uop_if.dst                 uop_in,
  input  logic [`WB_DATA_W-1:0] flags,
  output logic [`WB_DATA_W-1:0] step_value,
  output logic                  repne_term
);

  logic [`WB_DATA_W-1:0] step;
  logic [`WB_DATA_W-1:0] next_count;
  logic                  dir_down;

  // pointer step follows the operand size
  always_comb begin
    case (uop_in.uop.size)
      wb_pkg::WB_SIZE_BYTE:  step = `WB_DATA_W'd1;
      wb_pkg::WB_SIZE_WORD:  step = `WB_DATA_W'd2;
      wb_pkg::WB_SIZE_DWORD: step = `WB_DATA_W'd4;
      default:               step = `WB_DATA_W'd4;
    endcase
  end

  // DF from the flags already committed, not this micro-op's own update
  assign dir_down = flags[`WB_FLAG_DF];

  // count saturates at zero
  assign next_count = (uop_in.uop.count == '0) ? '0 :
                      uop_in.uop.count - `WB_DATA_W'd1;

  always_comb begin
    case (uop_in.uop.op)
      wb_pkg::WB_OP_CMPS: begin
        if (dir_down) begin
          step_value = uop_in.uop.pointer - step;
        end else begin
          step_value = uop_in.uop.pointer + step;
        end
      end
      wb_pkg::WB_OP_REPNE: step_value = next_count;
      default:             step_value = uop_in.uop.result;
    endcase
  end

  // loop ends on an exhausted count or on a match (ZF set)
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      repne_term <= 1'b0;
    end else if (uop_in.commit && (uop_in.uop.op == wb_pkg::WB_OP_REPNE)) begin
      repne_term <= (next_count == '0) || flags[`WB_FLAG_ZF];
    end
  end

endmodule

// ==== hw/wb_gpr_file.sv ====
// general register file: eight 32-bit registers, one write port, one async read port
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_gpr_file (
  input  logic                  clk,
  input  logic                  rst_n,
  wb_uop_if.dst                 uop_in,
  input  logic [`WB_DATA_W-1:0] step_value,
  input  logic [`WB_REG_W-1:0]  rd_addr,
  output logic [`WB_DATA_W-1:0] rd_data
);

  logic [`WB_DATA_W-1:0] regs [`WB_GPR_N];
  logic                  wr_en;
  logic [`WB_DATA_W-1:0] wr_data;

  // select write data by micro-op kind
  always_comb begin
    wr_en   = 1'b0;
    wr_data = uop_in.uop.result;
    case (uop_in.uop.op)
      wb_pkg::WB_OP_ALU: begin
        wr_en = uop_in.commit;
      end
      wb_pkg::WB_OP_CMPS,
      wb_pkg::WB_OP_REPNE: begin
        wr_en   = uop_in.commit;
        wr_data = step_value;
      end
      default: wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `WB_GPR_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[uop_in.uop.dst] <= wr_data;
    end
  end

  // observation port
  assign rd_data = regs[rd_addr];

endmodule

// ==== hw/wb_store_port.sv ====
// store port: four-phase sender of store address, data and size to the data cache
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_store_port (
  input  logic                  clk,
  input  logic                  rst_n,
  wb_uop_if.dst                 uop_in,
  output logic                  store_busy,
  output logic                  dc_req,
  input  logic                  dc_ack,
  output logic [`WB_DATA_W-1:0] dc_addr,
  output logic [`WB_DATA_W-1:0] dc_data,
  output wb_pkg::wb_size_e      dc_size
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_DROP
  } state_e;

  state_e state;
  logic   store_commit;

  assign store_commit = uop_in.commit && (uop_in.uop.op == wb_pkg::WB_OP_STORE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:      if (store_commit) state <= REQ;
        REQ:       if (dc_ack) state <= WAIT_DROP;
        // done once the cache releases ack
        WAIT_DROP: if (!dc_ack) state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  // store payload, held for the whole handshake
  always_ff @(posedge clk) begin
    if (store_commit && (state == IDLE)) begin
      dc_addr <= uop_in.uop.address;
      dc_data <= uop_in.uop.result;
      dc_size <= uop_in.uop.size;
    end
  end

  assign dc_req     = (state == REQ);
  assign store_busy = (state != IDLE);

endmodule

// ==== hw/wb_top.sv ====
// writeback top: input latch, flags and string units, register file and store port
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // execute stage channel
  input  logic                  in_req,
  input  wb_pkg::wb_uop_t       in_uop,
  output logic                  in_ack,

  // data cache channel
  output logic                  dc_req,
  input  logic                  dc_ack,
  output logic [`WB_DATA_W-1:0] dc_addr,
  output logic [`WB_DATA_W-1:0] dc_data,
  output wb_pkg::wb_size_e      dc_size,

  // observation
  input  logic [`WB_REG_W-1:0]  rd_addr,
  output logic [`WB_DATA_W-1:0] rd_data,
  output logic [`WB_DATA_W-1:0] flags,
  output logic                  repne_term
);

  logic                  store_busy;
  logic [`WB_DATA_W-1:0] step_value;

  wb_uop_if u_uop_if ();

  // input side
  wb_input_latch i_input_latch (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req     (in_req),
    .in_uop     (in_uop),
    .in_ack     (in_ack),
    .store_busy (store_busy),
    .uop_out    (u_uop_if.src)
  );

  // processing
  wb_flags_unit i_flags_unit (
    .clk    (clk),
    .rst_n  (rst_n),
    .uop_in (u_uop_if.dst),
    .flags  (flags)
  );

  wb_string_unit i_string_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_in     (u_uop_if.dst),
    .flags      (flags),
    .step_value (step_value),
    .repne_term (repne_term)
  );

  // output side
  wb_gpr_file i_gpr_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_in     (u_uop_if.dst),
    .step_value (step_value),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  wb_store_port i_store_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_in     (u_uop_if.dst),
    .store_busy (store_busy),
    .dc_req     (dc_req),
    .dc_ack     (dc_ack),
    .dc_addr    (dc_addr),
    .dc_data    (dc_data),
    .dc_size    (dc_size)
  );

endmodule

// ==== sim/wb_ref_model.svh ====
// writeback reference model: registers, flags, repne termination and expected stores
`ifndef WB_REF_MODEL_SVH
`define WB_REF_MODEL_SVH

typedef struct packed {
  logic [`WB_DATA_W-1:0] addr;
  logic [`WB_DATA_W-1:0] data;
  wb_pkg::wb_size_e      size;
} store_rec_t;

logic [`WB_DATA_W-1:0] model_regs [`WB_GPR_N];
logic [`WB_DATA_W-1:0] model_flags;
logic                  model_term;
store_rec_t            store_queue [$];

// mask bit 0 is CF, bit 6 is OF
function automatic logic [`WB_DATA_W-1:0] spread_mask(input logic [6:0] m);
  int                    pos [7];
  logic [`WB_DATA_W-1:0] w;
  pos = '{`WB_FLAG_CF, `WB_FLAG_PF, `WB_FLAG_AF, `WB_FLAG_ZF,
          `WB_FLAG_SF, `WB_FLAG_DF, `WB_FLAG_OF};
  w = '0;
  for (int i = 0; i < 7; i++) begin
    w[pos[i]] = m[i];
  end
  return w;
endfunction

function automatic void model_reset();
  for (int i = 0; i < `WB_GPR_N; i++) begin
    model_regs[i] = '0;
  end
  model_flags = '0;
  model_term  = 1'b0;
  store_queue.delete();
endfunction

// string ops see the flags from before their own micro-op
function automatic void model_commit(input wb_pkg::wb_uop_t u);
  logic [`WB_DATA_W-1:0] m;
  logic [`WB_DATA_W-1:0] step;
  logic [`WB_DATA_W-1:0] cnt;
  store_rec_t            rec;
  m    = spread_mask(u.flags_mask);
  step = `WB_DATA_W'(1) << u.size;
  case (u.op)
    wb_pkg::WB_OP_ALU: begin
      model_regs[u.dst] = u.result;
      model_flags       = (model_flags & ~m) | (u.new_flags & m);
    end
    wb_pkg::WB_OP_CMPS: begin
      model_regs[u.dst] = model_flags[`WB_FLAG_DF] ? u.pointer - step : u.pointer + step;
      model_flags       = (model_flags & ~m) | (u.new_flags & m);
    end
    wb_pkg::WB_OP_REPNE: begin
      cnt               = (u.count == 0) ? '0 : u.count - 1;
      model_regs[u.dst] = cnt;
      model_term        = (cnt == 0) || model_flags[`WB_FLAG_ZF];
    end
    wb_pkg::WB_OP_STORE: begin
      rec.addr = u.address;
      rec.data = u.result;
      rec.size = u.size;
      store_queue.push_back(rec);
    end
    default: begin
    end
  endcase
endfunction

`endif

// ==== sim/tb_wb_top.sv ====
// writeback testbench driving random micro-ops into the DUT and checking them against a model
`timescale 1ns/1ns
`include "wb_defines.svh"

module tb_wb_top;

  localparam int num_uops    = 400;
  localparam int half_period = 20;
  localparam int num_tests   = 5;
  localparam int test_alu    = 0;
  localparam int test_flags  = 1;
  localparam int test_cmps   = 2;
  localparam int test_repne  = 3;
  localparam int test_store  = 4;

  logic                  clk;
  logic                  rst_n;
  logic                  in_req;
  wb_pkg::wb_uop_t       in_uop;
  logic                  in_ack;
  logic                  dc_req;
  logic                  dc_ack;
  logic [`WB_DATA_W-1:0] dc_addr;
  logic [`WB_DATA_W-1:0] dc_data;
  wb_pkg::wb_size_e      dc_size;
  logic [`WB_REG_W-1:0]  rd_addr;
  logic [`WB_DATA_W-1:0] rd_data;
  logic [`WB_DATA_W-1:0] flags;
  logic                  repne_term;

  int    checks [num_tests];
  int    fails [num_tests];
  string names [num_tests] = '{"alu writes", "flag merge", "cmps stepping", "repne", "stores"};
  int    stores_sent;
  int    stores_done;

  `include "wb_ref_model.svh"

  wb_top i_dut (
    .clk(clk), .rst_n(rst_n), .in_req(in_req), .in_uop(in_uop), .in_ack(in_ack),
    .dc_req(dc_req), .dc_ack(dc_ack), .dc_addr(dc_addr), .dc_data(dc_data),
    .dc_size(dc_size), .rd_addr(rd_addr), .rd_data(rd_data), .flags(flags),
    .repne_term(repne_term)
  );

  always #half_period clk = ~clk;

  task automatic check_word(input int test, input logic [`WB_DATA_W-1:0] got,
                            input logic [`WB_DATA_W-1:0] exp, input string what);
    checks[test]++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      fails[test]++;
    end
  endtask

  // mostly ALU and CMPS with small counts so REPNE often reaches zero
  function automatic wb_pkg::wb_uop_t random_uop();
    wb_pkg::wb_uop_t u;
    int unsigned     pick;
    pick = $urandom_range(99);
    if (pick < 40) u.op = wb_pkg::WB_OP_ALU;
    else if (pick < 65) u.op = wb_pkg::WB_OP_CMPS;
    else if (pick < 80) u.op = wb_pkg::WB_OP_REPNE;
    else if (pick < 95) u.op = wb_pkg::WB_OP_STORE;
    else u.op = wb_pkg::WB_OP_NOP;
    case ($urandom_range(2))
      0: u.size = wb_pkg::WB_SIZE_BYTE;
      1: u.size = wb_pkg::WB_SIZE_WORD;
      default: u.size = wb_pkg::WB_SIZE_DWORD;
    endcase
    u.dst        = `WB_REG_W'($urandom_range(`WB_GPR_N - 1));
    u.result     = $urandom();
    u.pointer    = $urandom();
    u.count      = ($urandom_range(1) == 1) ? $urandom_range(3) : $urandom();
    u.address    = $urandom();
    u.new_flags  = $urandom();
    u.flags_mask = 7'($urandom_range(127));
    return u;
  endfunction

  // called and returns on a falling edge
  task automatic send_uop(input wb_pkg::wb_uop_t u);
    int test;
    in_uop = u;
    in_req = 1'b1;
    do @(negedge clk); while (!in_ack);
    if (u.op == wb_pkg::WB_OP_STORE) begin
      check_word(test_store, stores_done, stores_sent, "stores finished at store accept");
      stores_sent++;
    end
    model_commit(u);
    in_req = 1'b0;
    do @(negedge clk); while (in_ack);
    check_word(test_flags, flags, model_flags, "flags");
    check_word(test_flags, flags & ~spread_mask(7'h7f), '0, "flags outside flag bits");
    if (u.op == wb_pkg::WB_OP_REPNE) begin
      check_word(test_repne, 32'(repne_term), 32'(model_term), "repne_term");
    end
    case (u.op)
      wb_pkg::WB_OP_CMPS:  test = test_cmps;
      wb_pkg::WB_OP_REPNE: test = test_repne;
      default:             test = test_alu;
    endcase
    rd_addr = u.dst;
    @(negedge clk);
    check_word(test, rd_data, model_regs[u.dst], "destination register");
    rd_addr = `WB_REG_W'($urandom_range(`WB_GPR_N - 1));
    @(negedge clk);
    check_word(test_alu, rd_data, model_regs[rd_addr], "other register");
  endtask

  // cache side of the store channel
  initial begin
    store_rec_t exp;
    int         delay;
    forever begin
      @(negedge clk);
      if (dc_req && !dc_ack) begin
        checks[test_store]++;
        assert (store_queue.size() > 0) else begin
          $display("CHECK FAILED at %0t ns: cache request with no store outstanding", $time);
          fails[test_store]++;
        end
        if (store_queue.size() > 0) begin
          exp = store_queue.pop_front();
          check_word(test_store, dc_addr, exp.addr, "dc_addr");
          check_word(test_store, dc_data, exp.data, "dc_data");
          check_word(test_store, 32'(dc_size), 32'(exp.size), "dc_size");
        end
        delay = $urandom_range(5);
        repeat (delay) @(negedge clk);
        dc_ack = 1'b1;
        do @(negedge clk); while (dc_req);
        dc_ack = 1'b0;
        stores_done++;
      end
    end
  end

  initial begin
    #(num_uops * 20 * 2 * half_period);
    $display("timeout: the run did not finish in the time allowed for %0d micro-ops", num_uops);
    $display("sim failed");
    $finish;
  end

  initial begin
    int total_checks;
    int total_fails;
    int settle;
    void'($urandom(32'h8156));
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_req      = 1'b0;
    in_uop      = '0;
    dc_ack      = 1'b0;
    rd_addr     = '0;
    stores_sent = 0;
    stores_done = 0;
    model_reset();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < num_uops; i++) begin
      send_uop(random_uop());
    end
    // the last store may still be on the cache bus
    settle = 0;
    while ((stores_done != stores_sent) && (settle < 20)) begin
      @(negedge clk);
      settle++;
    end
    for (int r = 0; r < `WB_GPR_N; r++) begin
      rd_addr = `WB_REG_W'(r);
      @(negedge clk);
      check_word(test_alu, rd_data, model_regs[r], "final register sweep");
    end
    check_word(test_store, store_queue.size(), 0, "stores never sent to cache");
    total_checks = 0;
    total_fails  = 0;
    for (int t = 0; t < num_tests; t++) begin
      $display("test %s: %0d checks, %0d errors", names[t], checks[t], fails[t]);
      total_checks += checks[t];
      total_fails  += fails[t];
    end
    $display("total: %0d checks, %0d errors", total_checks, total_fails);
    if (total_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+hw
+incdir+sim
hw/wb_pkg.sv
hw/wb_uop_if.sv
hw/wb_input_latch.sv
hw/wb_flags_unit.sv
hw/wb_string_unit.sv
hw/wb_gpr_file.sv
hw/wb_store_port.sv
hw/wb_top.sv
sim/tb_wb_top.sv

// ==== Bender.yml ====
package:
  name: wb_retire

sources:
  - include_dirs:
      - hw
    files:
      - hw/wb_pkg.sv
      - hw/wb_uop_if.sv
      - hw/wb_input_latch.sv
      - hw/wb_flags_unit.sv
      - hw/wb_string_unit.sv
      - hw/wb_gpr_file.sv
      - hw/wb_store_port.sv
      - hw/wb_top.sv
  - target: simulation
    include_dirs:
      - hw
      - sim
    files:
      - sim/tb_wb_top.sv
